/* verilog/pi_bus_pkg.sv */
/*
 * Shared widths, codes and bundles for the two-master PI bus subsystem.
 * Masters, arbiter and top pull these in with a wildcard import of
 * pi_bus_pkg in their module headers.
 */
`default_nettype none

package pi_bus_pkg;

   localparam int NUM_MASTERS = 2;
   localparam int MST_ID_W    = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   // consecutive owned wait cycles before the bus gives up
   localparam int TOUT_CYCLES = 16;
   localparam int TOUT_W      = $clog2(TOUT_CYCLES);

   typedef logic [29:0]         pi_addr_t;  // word address
   typedef logic [31:0]         pi_data_t;
   typedef logic [3:0]          pi_opc_t;
   typedef logic [MST_ID_W-1:0] mst_id_t;
   typedef logic [TOUT_W-1:0]   tout_cnt_t;

   localparam pi_opc_t   OPC_SINGLE = 4'd0;
   localparam pi_opc_t   OPC_DOUBLE = 4'd1;  // two words
   localparam tout_cnt_t TOUT_LAST  = tout_cnt_t'(TOUT_CYCLES - 1);

   // slave acknowledge codes, undriven bus reads as a wait
   typedef enum logic [2:0] {
      ACK_WAT = 3'd0,
      ACK_RDY = 3'd1,
      ACK_RDM = 3'd2,  // same as rdy here
      ACK_ERR = 3'd3,
      ACK_RTR = 3'd4   // retract
   } pi_ack_t;

   typedef enum logic [2:0] {
      MST_IDLE,
      MST_REQ,
      MST_ADDR,
      MST_ADDR_DATA,
      MST_DATA,
      MST_RTRCT
   } mst_state_t;

   typedef struct packed {
      logic     valid;
      pi_addr_t addr;
      pi_opc_t  opc;
      logic     read;
      logic     lock;
   } pi_addr_phase_t;

   // held by the client until done or abort
   typedef struct packed {
      logic     rd;
      logic     wr;
      logic     lock;
      logic     size;    // 1 = two words
      pi_addr_t addr;
      pi_data_t wdata0;
      pi_data_t wdata1;
   } mst_req_t;

   // single cycle pulses back to the client
   typedef struct packed {
      logic     done;
      logic     abort;
      logic     restart;
      logic     rvalid;
      pi_data_t rdata;
   } mst_rsp_t;

endpackage

`default_nettype wire

/* verilog/pi_master.sv */
/*
 * PI bus master protocol engine, one per client.
 * Turns a held rd/wr level from the client into request, address phase,
 * optional overlapped second address, data phases and completion pulses.
 * Retract restarts the transfer from word 0, error or timeout aborts it.
 */
`timescale 1ns/1ps
`default_nettype none

module pi_master
   import pi_bus_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  mst_req_t       client_req,
   output mst_rsp_t       client_rsp,
   output logic           req,
   input  logic           gnt,
   output logic           bus_own,
   output pi_addr_phase_t addr_phase,
   output pi_data_t       wdata,
   input  pi_ack_t        ack,
   input  pi_data_t       din,
   input  logic           tout
);

   mst_state_t state;
   logic       word;       // data word in flight
   logic       done_q;
   logic       abort_q;
   logic       restart_q;
   logic       rvalid_q;
   pi_data_t   rdata_q;
   logic       start;
   logic       word_ok;
   logic       in_data;

   // skip the cycle where the client still sees its own completion
   assign start   = (client_req.rd | client_req.wr) & ~done_q & ~abort_q;
   assign word_ok = (ack == ACK_RDY) || (ack == ACK_RDM);
   assign in_data = (state == MST_ADDR_DATA) || (state == MST_DATA);

   assign req     = (state == MST_REQ);
   assign bus_own = (state == MST_ADDR) || in_data;
   assign wdata   = word ? client_req.wdata1 : client_req.wdata0;

   assign client_rsp = '{
      done:    done_q,
      abort:   abort_q,
      restart: restart_q,
      rvalid:  rvalid_q,
      rdata:   rdata_q
   };

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= MST_IDLE;
         word       <= 1'b0;
         addr_phase <= '0;
         done_q     <= 1'b0;
         abort_q    <= 1'b0;
         restart_q  <= 1'b0;
         rvalid_q   <= 1'b0;
      end
      else
      begin
         done_q    <= 1'b0;
         abort_q   <= 1'b0;
         restart_q <= 1'b0;
         rvalid_q  <= 1'b0;

         case (state)
            MST_IDLE:
            begin
               if (start)
                  state <= MST_REQ;
            end

            MST_REQ:
            begin
               if (gnt)
               begin
                  state            <= MST_ADDR;
                  word             <= 1'b0;
                  addr_phase.valid <= 1'b1;
                  addr_phase.addr  <= client_req.addr;
                  addr_phase.opc   <= client_req.size ? OPC_DOUBLE : OPC_SINGLE;
                  addr_phase.read  <= client_req.rd;
                  addr_phase.lock  <= client_req.lock;
               end
            end

            MST_ADDR:
            begin
               if (client_req.size)
               begin
                  // second address overlaps word 0 data
                  state           <= MST_ADDR_DATA;
                  addr_phase.addr <= addr_phase.addr + 30'd1;
               end
               else
               begin
                  state            <= MST_DATA;
                  addr_phase.valid <= 1'b0;
               end
            end

            MST_ADDR_DATA, MST_DATA:
            begin
               addr_phase.valid <= 1'b0;
               if (tout || ack == ACK_ERR)
               begin
                  state   <= MST_IDLE;
                  abort_q <= 1'b1;
               end
               else if (ack == ACK_RTR)
               begin
                  state     <= MST_RTRCT;
                  restart_q <= 1'b1;
               end
               else if (word_ok)
               begin
                  rvalid_q <= addr_phase.read;
                  if (state == MST_ADDR_DATA)
                  begin
                     state <= MST_DATA;
                     word  <= 1'b1;
                  end
                  else
                  begin
                     state  <= MST_IDLE;
                     done_q <= 1'b1;
                  end
               end
            end

            MST_RTRCT:
               state <= MST_REQ;  // bus released so ask again

            default:
               state <= MST_IDLE;
         endcase
      end
   end

   // read data capture
   always_ff @(posedge clk)
   begin
      if (in_data && word_ok && addr_phase.read)
         rdata_q <= din;
   end

   a_gnt_to_req: assert property (@(posedge clk) disable iff (!rst_n)
      gnt |-> req);

   a_valid_owned: assert property (@(posedge clk) disable iff (!rst_n)
      addr_phase.valid |-> bus_own);

endmodule

`default_nettype wire

/* verilog/pi_bus_arbiter.sv */
/*
 * Bus arbiter for the PI masters.
 * Round-robin grant pulses with lock hold, merge of the owning master's
 * address phase and write data onto the bus, and the wait-state timeout.
 */
`timescale 1ns/1ps
`default_nettype none

module pi_bus_arbiter
   import pi_bus_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [NUM_MASTERS-1:0] req,
   input  logic [NUM_MASTERS-1:0] bus_own,
   input  pi_addr_phase_t         mst_addr_phase [NUM_MASTERS],
   input  pi_data_t               mst_wdata [NUM_MASTERS],
   input  pi_ack_t                ack,
   output logic [NUM_MASTERS-1:0] gnt,
   output pi_addr_phase_t         bus_addr_phase,
   output pi_data_t               bus_dout,
   output logic                   tout
);

   mst_id_t                owner;
   mst_id_t                last_id;    // owner of the last address phase
   logic                   lock_hold;
   logic [NUM_MASTERS-1:0] rr_pick;
   logic                   rr_found;
   logic [NUM_MASTERS-1:0] pick;
   logic                   bus_free;
   logic                   data_ph;
   tout_cnt_t              wait_cnt;

   assign bus_free = ~|bus_own;

   // ownership merge
   always_comb
   begin
      owner          = '0;
      bus_addr_phase = '0;
      bus_dout       = '0;
      for (int i = 0; i < NUM_MASTERS; i++)
      begin
         if (bus_own[i])
         begin
            owner          = mst_id_t'(i);
            bus_addr_phase = mst_addr_phase[i];
            bus_dout       = mst_wdata[i];
         end
      end
   end

   // search starts just after the last owner
   always_comb
   begin
      rr_pick  = '0;
      rr_found = 1'b0;
      for (int i = 1; i <= NUM_MASTERS; i++)
      begin
         if (!rr_found && req[(int'(last_id) + i) % NUM_MASTERS])
         begin
            rr_pick[(int'(last_id) + i) % NUM_MASTERS] = 1'b1;
            rr_found = 1'b1;
         end
      end
   end

   always_comb
   begin
      pick = rr_pick;
      if (lock_hold)
      begin
         pick          = '0;
         pick[last_id] = req[last_id];  // others wait for the locked master
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         gnt       <= '0;
         last_id   <= mst_id_t'(NUM_MASTERS - 1);
         lock_hold <= 1'b0;
      end
      else
      begin
         gnt <= (bus_free && gnt == '0) ? pick : '0;
         if (bus_addr_phase.valid)
         begin
            last_id   <= owner;
            lock_hold <= bus_addr_phase.lock;
         end
      end
   end

   // wait-state timeout, counts only inside an owned data phase
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         data_ph  <= 1'b0;
         wait_cnt <= '0;
         tout     <= 1'b0;
      end
      else
      begin
         data_ph <= !bus_free && (data_ph || bus_addr_phase.valid);
         tout    <= 1'b0;
         if (data_ph && !bus_free && ack == ACK_WAT)
         begin
            if (wait_cnt == TOUT_LAST)
            begin
               tout     <= 1'b1;
               wait_cnt <= '0;
            end
            else
               wait_cnt <= wait_cnt + 1'b1;
         end
         else
            wait_cnt <= '0;
      end
   end

   a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(gnt));

   a_gnt_bus_free: assert property (@(posedge clk) disable iff (!rst_n)
      (|gnt) |-> bus_free);

endmodule

`default_nettype wire

/* verilog/pi_bus_top.sv */
/*
 * Two PI masters sharing one bus through the arbiter.
 * Client ports per master on one side, the PI bus toward the slave on
 * the other.
 */
`timescale 1ns/1ps
`default_nettype none

module pi_bus_top
   import pi_bus_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  mst_req_t       client_req0,
   input  mst_req_t       client_req1,
   output mst_rsp_t       client_rsp0,
   output mst_rsp_t       client_rsp1,
   output pi_addr_phase_t bus_addr_phase,
   output pi_data_t       bus_dout,
   input  pi_ack_t        ack,
   input  pi_data_t       din
);

   logic [NUM_MASTERS-1:0] req;
   logic [NUM_MASTERS-1:0] gnt;
   logic [NUM_MASTERS-1:0] bus_own;
   pi_addr_phase_t         mst_addr_phase [NUM_MASTERS];
   pi_data_t               mst_wdata [NUM_MASTERS];
   logic                   tout;   // broadcast to both masters

   pi_master u_mst0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .client_req (client_req0),
      .client_rsp (client_rsp0),
      .req        (req[0]),
      .gnt        (gnt[0]),
      .bus_own    (bus_own[0]),
      .addr_phase (mst_addr_phase[0]),
      .wdata      (mst_wdata[0]),
      .ack        (ack),
      .din        (din),
      .tout       (tout)
   );

   pi_master u_mst1 (
      .clk        (clk),
      .rst_n      (rst_n),
      .client_req (client_req1),
      .client_rsp (client_rsp1),
      .req        (req[1]),
      .gnt        (gnt[1]),
      .bus_own    (bus_own[1]),
      .addr_phase (mst_addr_phase[1]),
      .wdata      (mst_wdata[1]),
      .ack        (ack),
      .din        (din),
      .tout       (tout)
   );

   pi_bus_arbiter u_arb (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (req),
      .bus_own        (bus_own),
      .mst_addr_phase (mst_addr_phase),
      .mst_wdata      (mst_wdata),
      .ack            (ack),
      .gnt            (gnt),
      .bus_addr_phase (bus_addr_phase),
      .bus_dout       (bus_dout),
      .tout           (tout)
   );

endmodule

`default_nettype wire

/* verification/pi_bus_checks.svh */
/*
 * Typed compare tasks and error counters for the PI bus testbench.
 * Included inside the testbench module after its package import.
 */
`ifndef PI_BUS_CHECKS_SVH
`define PI_BUS_CHECKS_SVH

int err_cnt = 0;
int chk_cnt = 0;

task automatic check_data(input string name, input pi_data_t got, input pi_data_t exp);
   chk_cnt++;
   if (got !== exp)
   begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_addr(input string name, input pi_addr_t got, input pi_addr_t exp);
   chk_cnt++;
   if (got !== exp)
   begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
   end
endtask

// flags and event counts
task automatic check_flag(input string name, input logic got, input logic exp);
   chk_cnt++;
   if (got !== exp)
   begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_count(input string name, input int got, input int exp);
   chk_cnt++;
   if (got != exp)
   begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
   end
endtask

`endif

/* verification/pi_bus_tb.sv */
/*
 * Directed testbench for the two-master PI bus subsystem.
 * Acts as bus slave and as both clients, checks address phases, data,
 * retract, error, timeout and arbitration order.
 */
`timescale 1ns/1ps
`default_nettype none

module pi_bus_tb
   import pi_bus_pkg::*;
();

   logic           clk;
   logic           rst_n;
   mst_req_t       creq0, creq1;
   mst_rsp_t       rsp0, rsp1;
   pi_addr_phase_t bus_ap;
   pi_data_t       bus_dout;
   pi_data_t       din;
   pi_ack_t        ack;

   integer         seed = 32'h5d68f1e1;
   int             max_wait;      // upper bound of slave wait states per word
   pi_ack_t        answer_code;   // next answer only, then back to rdy
   logic           mute;          // slave ignores address phases
   logic           busy;
   int             wait_left;
   pi_addr_t       cur;
   int             ack_seen;
   int             cycles = 0;
   pi_addr_t       slave_q[$];
   pi_addr_phase_t ap_q[$];
   int             ap_acked_q[$];
   pi_data_t       dout_q[$];
   pi_data_t       rd_q0[$], rd_q1[$];
   int             done_n[2], abort_n[2], restart_n[2];

   `include "pi_bus_checks.svh"

   pi_bus_top uut (
      .clk(clk), .rst_n(rst_n),
      .client_req0(creq0), .client_req1(creq1),
      .client_rsp0(rsp0), .client_rsp1(rsp1),
      .bus_addr_phase(bus_ap), .bus_dout(bus_dout),
      .ack(ack), .din(din)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic pi_data_t slave_word(input pi_addr_t a);
      return {2'b00, a} ^ 32'h5d68f1e1;
   endfunction

   // slave model answering recorded words in order
   always @(posedge clk)
   begin
      #1;
      if (!busy && slave_q.size() > 0)
      begin
         cur = slave_q.pop_front();
         wait_left = (max_wait == 0) ? 0 : int'($unsigned($random(seed)) % (max_wait + 1));
         busy = 1'b1;
      end
      if (busy && wait_left == 0)
      begin
         ack = answer_code;
         din = slave_word(cur);
         answer_code = ACK_RDY;
         busy = 1'b0;
      end
      else
      begin
         if (busy)
            wait_left--;
         ack = ACK_WAT;
         din = '0;
      end
   end

   // bus and client monitor at mid cycle
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (bus_ap.valid)
         begin
            ap_q.push_back(bus_ap);
            ap_acked_q.push_back(ack_seen);  // words acked before this phase
            if (!mute)
               slave_q.push_back(bus_ap.addr);
         end
         if (ack == ACK_RDY || ack == ACK_RDM)
            dout_q.push_back(bus_dout);
         if (ack != ACK_WAT)
            ack_seen++;
         if (rsp0.rvalid)
            rd_q0.push_back(rsp0.rdata);
         if (rsp1.rvalid)
            rd_q1.push_back(rsp1.rdata);
         done_n[0] += int'(rsp0.done);
         done_n[1] += int'(rsp1.done);
         abort_n[0] += int'(rsp0.abort);
         abort_n[1] += int'(rsp1.abort);
         restart_n[0] += int'(rsp0.restart);
         restart_n[1] += int'(rsp1.restart);
      end
   end

   // about 16 transfers of under 80 cycles each
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= 4000)
      begin
         $display("run stopped, no finish after %0d cycles", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic mst_req_t make_req(input logic rd, input logic lock, input logic size,
                                         input pi_addr_t a, input pi_data_t w0, input pi_data_t w1);
      mst_req_t r;
      r = '0;
      r.rd = rd;
      r.wr = ~rd;
      r.lock = lock;
      r.size = size;
      r.addr = a;
      r.wdata0 = w0;
      r.wdata1 = w1;
      return r;
   endfunction

   function automatic logic ended(input int m);
      return (m == 0) ? (rsp0.done | rsp0.abort) : (rsp1.done | rsp1.abort);
   endfunction

   task automatic clear_logs();
      ap_q.delete();
      ap_acked_q.delete();
      dout_q.delete();
      rd_q0.delete();
      rd_q1.delete();
      done_n = '{0, 0};
      abort_n = '{0, 0};
      restart_n = '{0, 0};
      ack_seen = 0;
   endtask

   // hold the request level until done or abort
   task automatic run_client(input int m, input mst_req_t r);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      if (m == 0)
         creq0 = r;
      else
         creq1 = r;
      do
      begin
         @(negedge clk);
         n++;
      end while (!ended(m) && n < 200);
      if (!ended(m))
      begin
         $display("master %0d gave no done or abort within %0d cycles", m, n);
         err_cnt++;
      end
      @(posedge clk);
      #1;
      if (m == 0)
         creq0 = '0;
      else
         creq1 = '0;
   endtask

   task automatic check_reads(input int m, input pi_addr_t a, input int n);
      pi_data_t q[$];
      if (m == 0)
         q = rd_q0;
      else
         q = rd_q1;
      check_count("rvalid_count", q.size(), n);
      if (q.size() == n)
         for (int i = 0; i < n; i++)
            check_data("rdata", q[i], slave_word(a + pi_addr_t'(i)));
   endtask

   task automatic check_order(input pi_addr_t exp[$]);
      check_count("addr_phases", ap_q.size(), exp.size());
      if (ap_q.size() == exp.size())
         foreach (exp[i])
            check_addr("bus_addr", ap_q[i].addr, exp[i]);
   endtask

   task automatic report(input string name, input int e0);
      $display("%-14s %s, %0d errors", name, (err_cnt == e0) ? "ok" : "failed", err_cnt - e0);
   endtask

   task automatic t_single_read();
      int e;
      pi_addr_t a;
      e = err_cnt;
      for (int m = 0; m < 2; m++)
      begin
         a = 30'h0123400 + pi_addr_t'(m);
         clear_logs();
         run_client(m, make_req(1'b1, 1'b0, 1'b0, a, '0, '0));
         check_order('{a});
         if (ap_q.size() == 1)
         begin
            check_flag("opc_single", ap_q[0].opc == pi_opc_t'(0), 1'b1);
            check_flag("read", ap_q[0].read, 1'b1);
         end
         check_reads(m, a, 1);
         check_count("done", done_n[m], 1);
         check_count("abort", abort_n[m], 0);
      end
      report("single_read", e);
   endtask

   task automatic t_write();
      int e;
      pi_addr_t a;
      pi_data_t w;
      e = err_cnt;
      max_wait = 3;
      for (int m = 0; m < 2; m++)
      begin
         a = 30'h2a0050 + pi_addr_t'(m * 7);
         w = 32'hc0de0000 ^ {2'b00, a};
         clear_logs();
         run_client(m, make_req(1'b0, 1'b0, 1'b0, a, w, '0));
         check_count("rdy_count", dout_q.size(), 1);
         if (dout_q.size() == 1)
            check_data("bus_dout", dout_q[0], w);
         check_flag("write", (ap_q.size() > 0) ? ap_q[0].read : 1'b1, 1'b0);
         check_count("done", done_n[m], 1);
      end
      report("write", e);
   endtask

   task automatic t_double_read();
      int e;
      pi_addr_t a;
      e = err_cnt;
      a = 30'h3ff00e;
      clear_logs();
      run_client(1, make_req(1'b1, 1'b0, 1'b1, a, '0, '0));
      check_order('{a, a + 30'd1});
      if (ap_q.size() == 2)
      begin
         check_flag("opc_double", ap_q[0].opc == pi_opc_t'(1), 1'b1);
         check_count("acks_before_addr1", ap_acked_q[1], 0);
      end
      check_reads(1, a, 2);
      check_count("done", done_n[1], 1);
      report("double_read", e);
   endtask

   task automatic t_retract();
      int e;
      pi_addr_t a;
      e = err_cnt;
      a = 30'h0badd0;
      clear_logs();
      answer_code = ACK_RTR;
      run_client(0, make_req(1'b1, 1'b0, 1'b0, a, '0, '0));
      check_count("restart", restart_n[0], 1);
      check_order('{a, a});
      check_reads(0, a, 1);
      check_count("done", done_n[0], 1);
      report("retract", e);
   endtask

   task automatic t_err_tout();
      int e;
      pi_addr_t a;
      e = err_cnt;
      a = 30'h111111;
      clear_logs();
      answer_code = ACK_ERR;
      run_client(0, make_req(1'b1, 1'b0, 1'b0, a, '0, '0));
      check_count("abort_err", abort_n[0], 1);
      check_count("done_err", done_n[0], 0);
      check_reads(0, a, 0);
      clear_logs();
      mute = 1'b1;  // no answer so the bus times out
      run_client(0, make_req(1'b1, 1'b0, 1'b0, a, '0, '0));
      mute = 1'b0;
      check_count("abort_tout", abort_n[0], 1);
      check_count("done_tout", done_n[0], 0);
      clear_logs();
      run_client(0, make_req(1'b1, 1'b0, 1'b0, a, '0, '0));
      check_count("done_after", done_n[0], 1);
      check_reads(0, a, 1);
      report("err_tout", e);
   endtask

   task automatic t_arbitration();
      int e;
      e = err_cnt;
      clear_logs();
      // master 0 owned the bus last, so master 1 goes first
      fork
         begin
            run_client(0, make_req(1'b1, 1'b0, 1'b0, 30'h000a00, '0, '0));
            run_client(0, make_req(1'b1, 1'b0, 1'b0, 30'h000a01, '0, '0));
         end
         begin
            run_client(1, make_req(1'b1, 1'b0, 1'b0, 30'h000b00, '0, '0));
            run_client(1, make_req(1'b1, 1'b0, 1'b0, 30'h000b01, '0, '0));
         end
      join
      check_order('{30'h000b00, 30'h000a00, 30'h000b01, 30'h000a01});
      clear_logs();
      fork
         begin
            run_client(0, make_req(1'b1, 1'b1, 1'b0, 30'h000c00, '0, '0));
            run_client(0, make_req(1'b1, 1'b0, 1'b0, 30'h000c01, '0, '0));
         end
         begin
            while (ap_q.size() == 0)
               @(negedge clk);
            run_client(1, make_req(1'b1, 1'b0, 1'b0, 30'h000d00, '0, '0));
         end
      join
      check_order('{30'h000c00, 30'h000c01, 30'h000d00});
      if (ap_q.size() == 3)
      begin
         check_flag("lock_c00", ap_q[0].lock, 1'b1);
         check_flag("lock_c01", ap_q[1].lock, 1'b0);
      end
      check_count("done_m0", done_n[0], 2);
      check_count("done_m1", done_n[1], 1);
      report("arbitration", e);
   endtask

   initial
   begin
      rst_n = 1'b0;
      creq0 = '0;
      creq1 = '0;
      ack = ACK_WAT;
      din = '0;
      max_wait = 0;
      answer_code = ACK_RDY;
      mute = 1'b0;
      busy = 1'b0;
      wait_left = 0;
      ack_seen = 0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      t_single_read();
      t_write();
      t_double_read();
      t_retract();
      t_err_tout();
      t_arbitration();
      $display("%0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
verilog/pi_bus_pkg.sv
verilog/pi_master.sv
verilog/pi_bus_arbiter.sv
verilog/pi_bus_top.sv
+incdir+verification
verification/pi_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the PI bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pi_bus_tb \
   -f project.f -Mdir obj_dir -o pi_bus_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/pi_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
   echo "no pass line in sim.log"
   exit 1
fi
exit 0
